// ==== Makefile ====
# Verilator build and run for the UART testbench.

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/byte_fifo.sv ====
`timescale 1ns/1ps

`include "uart_defs.svh"

module byte_fifo #(
	parameter int DEPTH = `UART_FIFO_DEPTH
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_push,
	input  logic [7:0] i_wdata,
	input  logic       i_pop,
	output logic [7:0] o_rdata,
	output logic       o_empty,
	output logic       o_full
);

	localparam int ADDR_W = $clog2(DEPTH);

	logic [7:0] mem [DEPTH];

	// One extra bit tells full from empty when the addresses match.
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Storage.
	always_ff @(posedge i_clock) begin
		if (i_push) begin
			mem[wr_ptr[ADDR_W-1:0]] <= i_wdata;
		end
	end

	// Head byte shown ahead of the pop.
	assign o_rdata = mem[rd_ptr[ADDR_W-1:0]];

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
	                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	// The owner of the strobes must respect the flags.
	a_no_overflow: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> !o_full);

	a_no_underflow: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pop |-> !o_empty);

endmodule

// ==== logic/uart_defs.svh ====
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Clocks per serial bit.
// Whole clocks only, the bit timers have no fractional part.
`define UART_CLOCKS_PER_BIT 16

// Receive FIFO depth in bytes.
// Must be a power of two for the wrapping pointers.
`define UART_FIFO_DEPTH 8

// Width of one register on the bus.
`define UART_BUS_WIDTH 32

// Bits in one serial data word.
`define UART_DATA_BITS 8

`endif

// ==== logic/uart_pkg.sv ====
package uart_pkg;

	// Register map, one word per address.
	typedef enum logic [1:0] {
		REG_RX_DATA = 2'd0,
		REG_STATUS  = 2'd1,
		REG_TX_DATA = 2'd2,
		REG_CONTROL = 2'd3
	} uart_reg_addr_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// Request held by the bus master while i_req is high.
	typedef struct packed {
		uart_reg_addr_t address;
		logic           write;
		logic [31:0]    wdata;
		logic [5:0]     pad;
	} bus_req_t;

	typedef struct packed {
		logic [2:0] reserved;
		logic       irq_enable;
		logic       framing_error;
		logic       overrun;
		logic       tx_busy;
		logic       rx_empty;
	} uart_status_t;

endpackage

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_req,
	input  uart_pkg::bus_req_t i_bus_req,
	output logic               o_ack,
	output logic [31:0]        o_rdata,
	output logic               o_interrupt,
	output logic               o_fifo_push,
	output logic               o_fifo_pop,
	input  logic [7:0]         i_fifo_rdata,
	input  logic               i_fifo_empty,
	input  logic               i_fifo_full,
	input  logic               i_rx_valid,
	input  logic [7:0]         i_rx_byte,
	input  logic               i_rx_frame_error,
	output logic               o_tx_start,
	output logic [7:0]         o_tx_byte,
	input  logic               i_tx_busy
);

	import uart_pkg::*;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACKING,
		HS_RELEASE
	} hs_state_t;

	hs_state_t      hs_state;
	uart_reg_addr_t addr;
	uart_status_t   status;

	logic        irq_enable;
	logic        framing_error;
	logic        overrun;
	logic        tx_write;
	logic        ack_go;
	logic        is_read;
	logic [31:0] read_value;

	assign addr     = i_bus_req.address;
	assign is_read  = !i_bus_req.write;
	assign tx_write = i_bus_req.write && (addr == REG_TX_DATA);

	// Decode fires once, on the cycle before o_ack rises.
	// A TX write waits here while the serializer is busy.
	assign ack_go = (hs_state == HS_ACKING) && !(tx_write && i_tx_busy);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			hs_state <= HS_IDLE;
		end else begin
			case (hs_state)
				HS_IDLE: begin
					if (i_req) begin
						hs_state <= HS_ACKING;
					end
				end
				HS_ACKING: begin
					if (ack_go) begin
						hs_state <= HS_RELEASE;
					end
				end
				HS_RELEASE: begin
					if (!i_req) begin
						hs_state <= HS_IDLE;
					end
				end
				default: hs_state <= HS_IDLE;
			endcase
		end
	end

	assign o_ack = (hs_state == HS_RELEASE);

	// Strobes to the FIFO and serializer.
	assign o_fifo_pop  = ack_go && is_read && (addr == REG_RX_DATA) && !i_fifo_empty;
	assign o_tx_start  = ack_go && tx_write;
	assign o_tx_byte   = i_bus_req.wdata[7:0];
	assign o_fifo_push = i_rx_valid && !i_fifo_full;

	always_comb begin
		status               = '0;
		status.irq_enable    = irq_enable;
		status.framing_error = framing_error;
		status.overrun       = overrun;
		status.tx_busy       = i_tx_busy;
		status.rx_empty      = i_fifo_empty;
	end

	always_comb begin
		read_value = '0;
		case (addr)
			REG_RX_DATA: read_value = i_fifo_empty ? 32'd0 : {24'd0, i_fifo_rdata};
			REG_STATUS:  read_value = {24'd0, status};
			REG_CONTROL: read_value = {31'd0, irq_enable};
			default:     read_value = '0;
		endcase
	end

	// Captured as o_ack rises, held until the next read.
	always_ff @(posedge i_clock) begin
		if (ack_go && is_read) begin
			o_rdata <= read_value;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			irq_enable    <= 1'b0;
			framing_error <= 1'b0;
			overrun       <= 1'b0;
		end else begin
			if (ack_go && i_bus_req.write && addr == REG_CONTROL) begin
				irq_enable <= i_bus_req.wdata[0];
			end
			// Clear on status read; a new event in the same cycle wins.
			if (ack_go && is_read && addr == REG_STATUS) begin
				framing_error <= 1'b0;
				overrun       <= 1'b0;
			end
			if (i_rx_frame_error) begin
				framing_error <= 1'b1;
			end
			if (i_rx_valid && i_fifo_full) begin
				overrun <= 1'b1;
			end
		end
	end

	assign o_interrupt = irq_enable && !i_fifo_empty;

	// The request was still held on the edge that raised o_ack.
	a_ack_needs_req: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_ack) |-> $past(i_req));

	// Receiver must hand over a settled byte with its strobe.
	a_rx_byte_known: assert property (@(posedge i_clock) disable iff (i_reset)
		o_fifo_push |-> !$isunknown(i_rx_byte));

endmodule

// ==== logic/uart_rx_deframer.sv ====
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_rx_deframer #(
	parameter int CLOCKS_PER_BIT = `UART_CLOCKS_PER_BIT
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_rx,
	output logic       o_valid,
	output logic [7:0] o_byte,
	output logic       o_frame_error
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLOCKS_PER_BIT - 1);

	rx_state_t state;

	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] bit_count;
	logic [2:0]       bit_index;
	logic [7:0]       shift;
	logic             sample;

	// Two-flop synchronizer, idles high like the line.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// Bit timer expired, this is a sample point.
	assign sample = (bit_count == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= RX_IDLE;
			bit_count     <= '0;
			bit_index     <= '0;
			o_valid       <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			o_valid       <= 1'b0;
			o_frame_error <= 1'b0;
			if (!sample) begin
				bit_count <= bit_count - 1'b1;
			end
			case (state)
				RX_IDLE: begin
					// Falling edge, wait half a bit.
					if (!rx_sync) begin
						state     <= RX_START;
						bit_count <= HALF_BIT;
					end
				end
				RX_START: begin
					if (sample) begin
						if (rx_sync) begin
							// Glitch, not a start bit.
							state <= RX_IDLE;
						end else begin
							state     <= RX_DATA;
							bit_count <= FULL_BIT;
							bit_index <= '0;
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						bit_count <= FULL_BIT;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (sample) begin
						state <= RX_IDLE;
						if (rx_sync) begin
							o_valid <= 1'b1;
						end else begin
							o_frame_error <= 1'b1;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data arrives LSB first.
	always_ff @(posedge i_clock) begin
		if (state == RX_DATA && sample) begin
			shift <= {rx_sync, shift[7:1]};
		end
	end

	assign o_byte = shift;

	a_one_outcome: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_valid && o_frame_error));

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_top #(
	parameter int CLOCKS_PER_BIT = `UART_CLOCKS_PER_BIT,
	parameter int FIFO_DEPTH     = `UART_FIFO_DEPTH
) (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_req,
	input  uart_pkg::bus_req_t i_bus_req,
	output logic               o_ack,
	output logic [31:0]        o_rdata,
	output logic               o_interrupt,
	input  logic               i_rx,
	output logic               o_tx
);

	logic       fifo_push;
	logic       fifo_pop;
	logic [7:0] fifo_rdata;
	logic       fifo_empty;
	logic       fifo_full;
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       rx_frame_error;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;

	uart_regs regs_i (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_req            (i_req),
		.i_bus_req        (i_bus_req),
		.o_ack            (o_ack),
		.o_rdata          (o_rdata),
		.o_interrupt      (o_interrupt),
		.o_fifo_push      (fifo_push),
		.o_fifo_pop       (fifo_pop),
		.i_fifo_rdata     (fifo_rdata),
		.i_fifo_empty     (fifo_empty),
		.i_fifo_full      (fifo_full),
		.i_rx_valid       (rx_valid),
		.i_rx_byte        (rx_byte),
		.i_rx_frame_error (rx_frame_error),
		.o_tx_start       (tx_start),
		.o_tx_byte        (tx_byte),
		.i_tx_busy        (tx_busy)
	);

	byte_fifo #(
		.DEPTH (FIFO_DEPTH)
	) rx_fifo_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_push  (fifo_push),
		.i_wdata (rx_byte),
		.i_pop   (fifo_pop),
		.o_rdata (fifo_rdata),
		.o_empty (fifo_empty),
		.o_full  (fifo_full)
	);

	uart_rx_deframer #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) rx_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.o_valid       (rx_valid),
		.o_byte        (rx_byte),
		.o_frame_error (rx_frame_error)
	);

	uart_tx_serializer #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) tx_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_start (tx_start),
		.i_byte  (tx_byte),
		.o_tx    (o_tx),
		.o_busy  (tx_busy)
	);

endmodule

// ==== logic/uart_tx_serializer.sv ====
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tx_serializer #(
	parameter int CLOCKS_PER_BIT = `UART_CLOCKS_PER_BIT
) (
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_start,
	input  logic [7:0] i_byte,
	output logic       o_tx,
	output logic       o_busy
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLOCKS_PER_BIT - 1);

	tx_state_t state;

	logic [CNT_W-1:0] bit_count;
	logic [2:0]       bit_index;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (bit_count == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state     <= TX_IDLE;
			bit_count <= '0;
			bit_index <= '0;
			o_tx      <= 1'b1;
		end else begin
			if (!bit_end) begin
				bit_count <= bit_count - 1'b1;
			end
			case (state)
				TX_IDLE: begin
					if (i_start) begin
						state     <= TX_START;
						bit_count <= FULL_BIT;
						o_tx      <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state     <= TX_DATA;
						bit_count <= FULL_BIT;
						bit_index <= '0;
						o_tx      <= shift[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_count <= FULL_BIT;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= TX_STOP;
							o_tx  <= 1'b1;
						end else begin
							o_tx <= shift[1];
						end
					end
				end
				TX_STOP: begin
					// Busy drops once the stop bit is complete.
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Shift register, bit 0 is the next data bit on the line.
	always_ff @(posedge i_clock) begin
		if (state == TX_IDLE && i_start) begin
			shift <= i_byte;
		end else if (state == TX_DATA && bit_end) begin
			shift <= shift >> 1;
		end
	end

	assign o_busy = (state != TX_IDLE);

	a_start_when_free: assert property (@(posedge i_clock) disable iff (i_reset)
		i_start |-> !o_busy);

endmodule

// ==== test/uart_tb.sv ====
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int CPB            = `UART_CLOCKS_PER_BIT;
	localparam int DEPTH          = `UART_FIFO_DEPTH;
	localparam int TIMEOUT_CYCLES = 40 * 10 * CPB + 2000;

	logic        i_clock;
	logic        i_reset;
	logic        i_req;
	bus_req_t    i_bus_req;
	logic        o_ack;
	logic [31:0] o_rdata;
	logic        o_interrupt;
	logic        i_rx;
	logic        o_tx;

	logic [7:0]  model_fifo [$];
	logic [7:0]  tx_q [$];
	logic        m_irq_enable;
	logic        m_framing;
	logic        m_overrun;
	logic [31:0] rng_state;
	int          errors;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	int          cycle_count;

	uart_top dut_i (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_req       (i_req),
		.i_bus_req   (i_bus_req),
		.o_ack       (o_ack),
		.o_rdata     (o_rdata),
		.o_interrupt (o_interrupt),
		.i_rx        (i_rx),
		.o_tx        (o_tx)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [7:0] random_byte();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[23:16];
	endfunction

	// Expected status from the FIFO model and the model flags.
	function automatic uart_status_t model_status(input logic exp_tx_busy);
		uart_status_t s;
		s               = '0;
		s.irq_enable    = m_irq_enable;
		s.framing_error = m_framing;
		s.overrun       = m_overrun;
		s.tx_busy       = exp_tx_busy;
		s.rx_empty      = (model_fifo.size() == 0);
		return s;
	endfunction

	// A full FIFO drops the byte.
	function automatic void model_receive(input logic [7:0] b);
		if (model_fifo.size() == DEPTH) begin
			m_overrun = 1'b1;
		end else begin
			model_fifo.push_back(b);
		end
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %02h actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input uart_status_t exp,
	                            input uart_status_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %02h actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge i_clock);
		#1;
	endtask

	// Four-phase access, ack sampled 1 ns after the edge.
	task automatic bus_access(input uart_reg_addr_t a, input logic wr, input logic [31:0] wd,
	                          output logic [31:0] rd);
		i_bus_req.address = a;
		i_bus_req.write   = wr;
		i_bus_req.wdata   = wd;
		i_bus_req.pad     = '0;
		i_req             = 1'b1;
		do wait_cycles(1); while (!o_ack);
		rd    = o_rdata;
		i_req = 1'b0;
		do wait_cycles(1); while (o_ack);
	endtask

	task automatic bus_read(input uart_reg_addr_t a, output logic [31:0] rd);
		bus_access(a, 1'b0, 32'd0, rd);
	endtask

	task automatic bus_write(input uart_reg_addr_t a, input logic [31:0] wd);
		logic [31:0] unused_rd;
		bus_access(a, 1'b1, wd, unused_rd);
	endtask

	task automatic send_serial(input logic [7:0] b, input logic bad_stop);
		i_rx = 1'b0;
		wait_cycles(CPB);
		for (int i = 0; i < 8; i++) begin
			i_rx = b[i];
			wait_cycles(CPB);
		end
		i_rx = !bad_stop;
		wait_cycles(CPB);
		i_rx = 1'b1;
	endtask

	task automatic expect_status(input string name, input logic exp_busy);
		logic [31:0] rd;
		uart_status_t exp;
		exp = model_status(exp_busy);
		bus_read(REG_STATUS, rd);
		check_status(name, exp, uart_status_t'(rd[7:0]));
		// Sticky flags clear on the read.
		m_framing = 1'b0;
		m_overrun = 1'b0;
	endtask

	task automatic expect_rx_byte(input string name);
		logic [31:0] rd;
		logic [7:0]  exp;
		exp = 8'h00;
		if (model_fifo.size() > 0) begin
			exp = model_fifo.pop_front();
		end
		bus_read(REG_RX_DATA, rd);
		check_byte(name, exp, rd[7:0]);
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errors) begin
			pass_count++;
			$display("%s: passed", name);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// Line monitor, samples o_tx mid-bit on the falling clock edge.
	initial begin
		logic [7:0] b;
		@(negedge i_reset);
		forever begin
			@(negedge o_tx);
			repeat (CPB / 2) @(negedge i_clock);
			if (o_tx !== 1'b0) begin
				$display("Monitor: start bit on o_tx did not hold low");
				errors++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge i_clock);
				b[i] = o_tx;
			end
			repeat (CPB) @(negedge i_clock);
			if (o_tx !== 1'b1) begin
				$display("Monitor: stop bit on o_tx was low");
				errors++;
			end
			tx_q.push_back(b);
		end
	end

	initial begin
		logic [7:0] b;
		logic [7:0] tx_sent [3];
		i_reset      = 1'b1;
		i_req        = 1'b0;
		i_bus_req    = '0;
		i_rx         = 1'b1;
		m_irq_enable = 1'b0;
		m_framing    = 1'b0;
		m_overrun    = 1'b0;
		rng_state    = 32'hb80f;
		errors       = 0;
		test_errors  = 0;
		pass_count   = 0;
		fail_count   = 0;
		cycle_count  = 0;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		wait_cycles(2);

		expect_status("reset_status", 1'b0);
		check_bit("reset_tx", 1'b1, o_tx);
		check_bit("reset_irq", 1'b0, o_interrupt);
		finish_test("reset");

		for (int k = 0; k < 20; k++) begin
			b = random_byte();
			send_serial(b, 1'b0);
			model_receive(b);
			expect_rx_byte("rx_byte");
		end
		expect_rx_byte("rx_empty_read");
		finish_test("rx_random");

		send_serial(random_byte(), 1'b1);
		m_framing = 1'b1;
		wait_cycles(CPB);
		expect_status("framing_set", 1'b0);
		expect_status("framing_clear", 1'b0);
		finish_test("framing_error");

		for (int k = 0; k < DEPTH + 1; k++) begin
			b = random_byte();
			send_serial(b, 1'b0);
			model_receive(b);
		end
		expect_status("overrun_set", 1'b0);
		expect_status("overrun_clear", 1'b0);
		for (int k = 0; k < DEPTH; k++) begin
			expect_rx_byte("overrun_byte");
		end
		expect_rx_byte("overrun_empty_read");
		finish_test("overrun");

		for (int k = 0; k < 3; k++) begin
			tx_sent[k] = random_byte();
			bus_write(REG_TX_DATA, {24'd0, tx_sent[k]});
			if (k > 0 && tx_q.size() < k) begin
				$display("TX write %0d finished before the previous frame ended", k);
				errors++;
			end
			expect_status("tx_busy", 1'b1);
		end
		while (tx_q.size() < 3) begin
			wait_cycles(1);
		end
		wait_cycles(CPB);
		expect_status("tx_idle", 1'b0);
		for (int k = 0; k < 3; k++) begin
			check_byte("tx_line", tx_sent[k], tx_q.pop_front());
		end
		finish_test("tx_back_to_back");

		bus_write(REG_CONTROL, 32'd1);
		m_irq_enable = 1'b1;
		b = random_byte();
		send_serial(b, 1'b0);
		model_receive(b);
		check_bit("irq_high", 1'b1, o_interrupt);
		expect_status("irq_status", 1'b0);
		expect_rx_byte("irq_byte");
		check_bit("irq_low_empty", 1'b0, o_interrupt);
		bus_write(REG_CONTROL, 32'd0);
		m_irq_enable = 1'b0;
		b = random_byte();
		send_serial(b, 1'b0);
		model_receive(b);
		check_bit("irq_disabled", 1'b0, o_interrupt);
		expect_rx_byte("irq_disabled_byte");
		finish_test("interrupt");

		$display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/uart_pkg.sv
logic/byte_fifo.sv
logic/uart_rx_deframer.sv
logic/uart_tx_serializer.sv
logic/uart_regs.sv
logic/uart_top.sv
test/uart_tb.sv
